// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing
TOP      := tb_soc_fpga_wrapper
FILELIST := tb.f
OBJDIR   := obj_dir

BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Finished with no errors'

clean:
	rm -rf $(OBJDIR)

// File: common/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

//----------------------------------------------------------------------
// External memory geometry
//----------------------------------------------------------------------

`define MEM_ADDR_W 8                  // Word address bits.
`define MEM_DATA_W 32                 // Bits per word.
`define MEM_DEPTH  (1 << `MEM_ADDR_W) // Words in the array.

//----------------------------------------------------------------------
// Reset sequencing
//----------------------------------------------------------------------

// Cycles the system stays in reset once memory init completes.
`define RST_HOLD_CYCLES 4

`endif

// File: common/soc_pkg.sv
`include "soc_consts.svh"

package soc_pkg;

   //-------------------------------------------------------------------
   // Bus payload types
   //-------------------------------------------------------------------

   typedef logic [`MEM_ADDR_W-1:0] mem_addr_t; // One word address.
   typedef logic [`MEM_DATA_W-1:0] mem_data_t; // One data word.

   //-------------------------------------------------------------------
   // FSM encodings
   //-------------------------------------------------------------------

   // Reset generator sequence.
   typedef enum logic [1:0] {
      WAIT_INIT = 2'd0,   // Memory still clearing.
      HOLD      = 2'd1,   // Init done, counting hold.
      RUN       = 2'd2    // System released.
   } rst_state_e;

   // External memory mode.
   typedef enum logic {
      CLEARING = 1'b0,    // Zero fill in progress.
      SERVING  = 1'b1     // Normal accesses.
   } mem_state_e;

endpackage

// File: ext_mem/ext_mem.sv
`include "soc_consts.svh"

module ext_mem (
   input  logic               clk_i,       // System clock.
   input  logic               reset_i,     // Board reset, restarts clear.
   input  logic               en_i,        // Access strobe.
   input  logic               we_i,        // Write on this access.
   input  soc_pkg::mem_addr_t addr_i,      // Word address.
   input  soc_pkg::mem_data_t wdata_i,     // Word to store.
   output soc_pkg::mem_data_t rdata_o,     // Old word at addr_i.
   output logic               init_done_o  // Clear finished.
);

   soc_pkg::mem_data_t  mem_q [`MEM_DEPTH];  // Storage array.
   soc_pkg::mem_state_e state_q;             // Clear or serve.
   soc_pkg::mem_addr_t  clr_addr_q;          // Next word to zero.
   logic                clearing;            // Zero fill active.
   logic                serving;             // Accesses allowed.

   assign clearing = (state_q == soc_pkg::CLEARING) & ~reset_i;
   assign serving  = (state_q == soc_pkg::SERVING);

   //-------------------------------------------------------------------
   // Clear sequencer
   //-------------------------------------------------------------------

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q     <= soc_pkg::CLEARING;
         clr_addr_q  <= '0;
         init_done_o <= 1'b0;
      end else if (clearing) begin
         clr_addr_q <= clr_addr_q + 1'b1;        // One word per cycle.
         if (clr_addr_q == '1) begin
            state_q     <= soc_pkg::SERVING;     // Last word zeroed.
            init_done_o <= 1'b1;
         end
      end
   end

   //-------------------------------------------------------------------
   // Array port
   //-------------------------------------------------------------------

   // Read and write share one edge, so the read sees the old word.
   always_ff @(posedge clk_i) begin
      if (clearing) begin
         mem_q[clr_addr_q] <= '0;
      end else if (serving && en_i) begin
         rdata_o <= mem_q[addr_i];
         if (we_i) mem_q[addr_i] <= wdata_i;
      end
   end

endmodule

// File: mem_arbiter/mem_arbiter.sv
module mem_arbiter (
   input  logic               clk_i,          // System clock.
   input  logic               sys_rst_i,      // Fabric reset.
   // Master port A.
   input  logic               port_a_req_i,   // One-cycle strobe.
   input  logic               port_a_we_i,    // Write enable.
   input  soc_pkg::mem_addr_t port_a_addr_i,  // Word address.
   input  soc_pkg::mem_data_t port_a_wdata_i, // Write data.
   output logic               port_a_done_o,  // One-cycle completion.
   output soc_pkg::mem_data_t port_a_rdata_o, // Valid with done.
   // Master port B.
   input  logic               port_b_req_i,
   input  logic               port_b_we_i,
   input  soc_pkg::mem_addr_t port_b_addr_i,
   input  soc_pkg::mem_data_t port_b_wdata_i,
   output logic               port_b_done_o,
   output soc_pkg::mem_data_t port_b_rdata_o,
   // Memory side.
   output logic               mem_en_o,       // Access this cycle.
   output logic               mem_we_o,       // Write this cycle.
   output soc_pkg::mem_addr_t mem_addr_o,
   output soc_pkg::mem_data_t mem_wdata_o,
   input  soc_pkg::mem_data_t mem_rdata_i     // Old word, one cycle later.
);

   logic               pend_a_q, pend_b_q;            // Request waiting.
   logic               pend_a_we_q, pend_b_we_q;      // Captured write enables.
   soc_pkg::mem_addr_t pend_a_addr_q, pend_b_addr_q;  // Captured addresses.
   soc_pkg::mem_data_t pend_a_wdata_q, pend_b_wdata_q;
   logic               ptr_q;        // 0 favors A, 1 favors B.
   logic               gnt_a, gnt_b; // Winner this cycle.
   logic               contend;      // Both ports waiting.
   logic               iss_port_q;   // Port behind mem_en_o, 1 is B.
   logic               rsp_valid_q;  // Memory data valid now.
   logic               rsp_port_q;   // Port owning the data.

   //-------------------------------------------------------------------
   // Request capture
   //-------------------------------------------------------------------

   always_ff @(posedge clk_i) begin
      if (sys_rst_i) begin
         pend_a_q <= 1'b0;                       // Strobes in reset dropped.
         pend_b_q <= 1'b0;
      end else begin
         if (port_a_req_i)  pend_a_q <= 1'b1;
         else if (gnt_a)    pend_a_q <= 1'b0;    // Issued to memory.
         if (port_b_req_i)  pend_b_q <= 1'b1;
         else if (gnt_b)    pend_b_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (port_a_req_i) begin
         pend_a_we_q    <= port_a_we_i;
         pend_a_addr_q  <= port_a_addr_i;
         pend_a_wdata_q <= port_a_wdata_i;
      end
      if (port_b_req_i) begin
         pend_b_we_q    <= port_b_we_i;
         pend_b_addr_q  <= port_b_addr_i;
         pend_b_wdata_q <= port_b_wdata_i;
      end
   end

   //-------------------------------------------------------------------
   // Round-robin grant
   //-------------------------------------------------------------------

   assign contend = pend_a_q & pend_b_q;
   assign gnt_a   = pend_a_q & (~pend_b_q | ~ptr_q); // Alone, or favored.
   assign gnt_b   = pend_b_q & (~pend_a_q | ptr_q);

   // Pointer only turns on a real contest, away from the winner.
   always_ff @(posedge clk_i) begin
      if (sys_rst_i)    ptr_q <= 1'b0;           // A first after reset.
      else if (contend) ptr_q <= gnt_a;
   end

   //-------------------------------------------------------------------
   // Issue and response tracking
   //-------------------------------------------------------------------

   always_ff @(posedge clk_i) begin
      if (sys_rst_i) begin
         mem_en_o    <= 1'b0;
         mem_we_o    <= 1'b0;
         iss_port_q  <= 1'b0;
         rsp_valid_q <= 1'b0;
         rsp_port_q  <= 1'b0;
      end else begin
         mem_en_o    <= gnt_a | gnt_b;
         mem_we_o    <= gnt_b ? pend_b_we_q : (gnt_a & pend_a_we_q);
         iss_port_q  <= gnt_b;
         rsp_valid_q <= mem_en_o;                // Memory answers next cycle.
         rsp_port_q  <= iss_port_q;
      end
   end

   always_ff @(posedge clk_i) begin
      mem_addr_o  <= gnt_b ? pend_b_addr_q  : pend_a_addr_q;
      mem_wdata_o <= gnt_b ? pend_b_wdata_q : pend_a_wdata_q;
   end

   assign port_a_done_o  = rsp_valid_q & ~rsp_port_q;
   assign port_b_done_o  = rsp_valid_q & rsp_port_q;
   assign port_a_rdata_o = mem_rdata_i;          // Shared return path.
   assign port_b_rdata_o = mem_rdata_i;

endmodule

// File: src/soc_fpga_wrapper.sv
module soc_fpga_wrapper (
   input  logic               clk_i,          // Board clock.
   input  logic               reset_i,        // Board reset, sync, active high.
   // Master port A.
   input  logic               port_a_req_i,
   input  logic               port_a_we_i,
   input  soc_pkg::mem_addr_t port_a_addr_i,
   input  soc_pkg::mem_data_t port_a_wdata_i,
   output logic               port_a_done_o,
   output soc_pkg::mem_data_t port_a_rdata_o,
   // Master port B.
   input  logic               port_b_req_i,
   input  logic               port_b_we_i,
   input  soc_pkg::mem_addr_t port_b_addr_i,
   input  soc_pkg::mem_data_t port_b_wdata_i,
   output logic               port_b_done_o,
   output soc_pkg::mem_data_t port_b_rdata_o,
   output logic               ready_o         // System running.
);

   //-------------------------------------------------------------------
   // Reset and memory interconnect
   //-------------------------------------------------------------------

   logic               init_done;   // Memory clear complete.
   logic               sys_rst;     // Fabric reset.
   logic               mem_en;
   logic               mem_we;
   soc_pkg::mem_addr_t mem_addr;
   soc_pkg::mem_data_t mem_wdata;
   soc_pkg::mem_data_t mem_rdata;

   sys_reset_gen u_rst (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .init_done_i(init_done),
      .sys_rst_o  (sys_rst),
      .ready_o    (ready_o)
   );

   mem_arbiter u_arb (
      .clk_i         (clk_i),
      .sys_rst_i     (sys_rst),
      .port_a_req_i  (port_a_req_i),
      .port_a_we_i   (port_a_we_i),
      .port_a_addr_i (port_a_addr_i),
      .port_a_wdata_i(port_a_wdata_i),
      .port_a_done_o (port_a_done_o),
      .port_a_rdata_o(port_a_rdata_o),
      .port_b_req_i  (port_b_req_i),
      .port_b_we_i   (port_b_we_i),
      .port_b_addr_i (port_b_addr_i),
      .port_b_wdata_i(port_b_wdata_i),
      .port_b_done_o (port_b_done_o),
      .port_b_rdata_o(port_b_rdata_o),
      .mem_en_o      (mem_en),
      .mem_we_o      (mem_we),
      .mem_addr_o    (mem_addr),
      .mem_wdata_o   (mem_wdata),
      .mem_rdata_i   (mem_rdata)
   );

   // Memory clears on the board reset, not the fabric reset.
   ext_mem u_mem (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .en_i       (mem_en),
      .we_i       (mem_we),
      .addr_i     (mem_addr),
      .wdata_i    (mem_wdata),
      .rdata_o    (mem_rdata),
      .init_done_o(init_done)
   );

endmodule

// File: src/sys_reset_gen.sv
`include "soc_consts.svh"

module sys_reset_gen (
   input  logic clk_i,        // System clock.
   input  logic reset_i,      // Board reset, sync, active high.
   input  logic init_done_i,  // Memory finished clearing.
   output logic sys_rst_o,    // Reset for the bus fabric.
   output logic ready_o       // System out of reset.
);

   // Counter just wide enough for the hold length.
   localparam int unsigned HOLD_W = $clog2(`RST_HOLD_CYCLES + 1);
   localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`RST_HOLD_CYCLES - 1);

   soc_pkg::rst_state_e state_q;      // Sequencer state.
   logic [HOLD_W-1:0]   hold_cnt_q;   // Cycles spent in HOLD.

   //-------------------------------------------------------------------
   // Sequencer
   //-------------------------------------------------------------------

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q    <= soc_pkg::WAIT_INIT;
         hold_cnt_q <= '0;
         sys_rst_o  <= 1'b1;                       // Held from the first edge.
         ready_o    <= 1'b0;
      end else begin
         case (state_q)
            soc_pkg::WAIT_INIT: begin
               hold_cnt_q <= '0;
               if (init_done_i) state_q <= soc_pkg::HOLD; // Memory usable.
            end
            soc_pkg::HOLD: begin
               if (hold_cnt_q == HOLD_LAST) begin
                  state_q   <= soc_pkg::RUN;        // Hold expired.
                  sys_rst_o <= 1'b0;
                  ready_o   <= 1'b1;
               end else begin
                  hold_cnt_q <= hold_cnt_q + 1'b1;
               end
            end
            default: begin
               sys_rst_o <= 1'b0;                   // Stay released.
               ready_o   <= 1'b1;
            end
         endcase
      end
   end

endmodule

// File: tb.f
+incdir+common
common/soc_pkg.sv
src/sys_reset_gen.sv
mem_arbiter/mem_arbiter.sv
ext_mem/ext_mem.sv
src/soc_fpga_wrapper.sv
verif/tb_soc_fpga_wrapper.sv

// File: verif/tb_soc_fpga_wrapper.sv
`include "soc_consts.svh"

module tb_soc_fpga_wrapper;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int INIT_BUDGET = `MEM_DEPTH + `RST_HOLD_CYCLES + 2; // Clear plus hold.
   localparam int N_RAND      = 200;                               // Random rounds.
   localparam int ACC_LIMIT   = 10;                                // Cycles to wait for done.
   localparam int TIMEOUT_CYCLES = 2 * (6 + INIT_BUDGET + 4) + (40 + N_RAND) * 6 + 200;

   logic               clk, reset, ready;
   logic               a_req, a_we, a_done;
   logic               b_req, b_we, b_done;
   soc_pkg::mem_addr_t a_addr, b_addr;
   soc_pkg::mem_data_t a_wdata, a_rdata, b_wdata, b_rdata;

   soc_pkg::mem_data_t ref_mem [`MEM_DEPTH]; // Expected array contents.
   logic               ref_ptr;              // Set when B is favored.
   int                 errors = 0;
   int                 checks = 0;

   soc_fpga_wrapper dut_i (
      .clk_i(clk), .reset_i(reset),
      .port_a_req_i(a_req), .port_a_we_i(a_we), .port_a_addr_i(a_addr),
      .port_a_wdata_i(a_wdata), .port_a_done_o(a_done), .port_a_rdata_o(a_rdata),
      .port_b_req_i(b_req), .port_b_we_i(b_we), .port_b_addr_i(b_addr),
      .port_b_wdata_i(b_wdata), .port_b_done_o(b_done), .port_b_rdata_o(b_rdata),
      .ready_o(ready)
   );

   always #20 clk = ~clk;                   // 40 ns period.

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Run timed out after %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
   end

   //----------------------------------------------------------------------
   // Checking and reference model
   //----------------------------------------------------------------------

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0d ns: %s: got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   // Old word out, new word in.
   function automatic soc_pkg::mem_data_t ref_access(input logic we,
         input soc_pkg::mem_addr_t addr, input soc_pkg::mem_data_t wdata);
      soc_pkg::mem_data_t old;
      old = ref_mem[addr];
      if (we) ref_mem[addr] = wdata;
      return old;
   endfunction

   task automatic report(input string name, input int err_start);
      $display("Test %s done, %0d errors", name, errors - err_start);
   endtask

   //----------------------------------------------------------------------
   // Drivers
   //----------------------------------------------------------------------

   task automatic apply_reset();
      @(posedge clk);
      reset <= 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      foreach (ref_mem[i]) ref_mem[i] = '0; // Memory clears on every reset.
      ref_ptr = 1'b0;                       // A favored again.
   endtask

   // Optionally pokes both ports while still in reset.
   task automatic wait_ready(input logic poke, output logic saw_done);
      int n;
      n = 0;
      saw_done = 1'b0;
      @(negedge clk);
      check_value(32'(ready), 32'd0, "ready_o right after reset");
      while (!ready && n < INIT_BUDGET) begin
         @(posedge clk);
         a_req   <= poke && (n == 9);
         b_req   <= poke && (n == 9);
         a_we    <= 1'b1;                    // Would corrupt address 0 if it leaked.
         a_addr  <= '0;
         a_wdata <= 32'h0bad_0bad;
         @(negedge clk);
         n++;
         saw_done |= a_done | b_done;
      end
      check_value(32'(ready), 32'd1, "ready_o within init budget");
      repeat (4) begin
         @(negedge clk);
         saw_done |= a_done | b_done;
      end
   endtask

   // Strobe one port, return read data and cycles from sample edge to done.
   task automatic run_access(input logic port_b, input logic we,
         input soc_pkg::mem_addr_t addr, input soc_pkg::mem_data_t wdata,
         output soc_pkg::mem_data_t rdata, output int lat);
      logic found;
      found = 1'b0;
      rdata = '0;
      lat   = 0;
      @(posedge clk);
      if (port_b) begin
         b_req   <= 1'b1;
         b_we    <= we;
         b_addr  <= addr;
         b_wdata <= wdata;
      end else begin
         a_req   <= 1'b1;
         a_we    <= we;
         a_addr  <= addr;
         a_wdata <= wdata;
      end
      @(posedge clk);                       // Strobe sampled here.
      if (port_b) b_req <= 1'b0;
      else a_req <= 1'b0;
      while (!found && lat < ACC_LIMIT) begin
         @(posedge clk);
         lat++;
         @(negedge clk);
         found = port_b ? b_done : a_done;
         rdata = port_b ? b_rdata : a_rdata;
      end
      if (!found) begin
         errors++;
         $display("Port %s got no done pulse within %0d cycles at %0d ns",
                  port_b ? "B" : "A", ACC_LIMIT, $time);
         lat = -1;
      end
   endtask

   task automatic single_access(input logic port_b, input logic we,
         input soc_pkg::mem_addr_t addr, input soc_pkg::mem_data_t wdata, input string tag);
      soc_pkg::mem_data_t exp, got;
      int lat;
      exp = ref_access(we, addr, wdata);
      run_access(port_b, we, addr, wdata, got, lat);
      check_value(lat, 2, {tag, " latency"});
      check_value(got, exp, {tag, " rdata"});
   endtask

   // Both ports strobe on the same edge.
   task automatic paired_access(input logic we_a, input soc_pkg::mem_addr_t addr_a,
         input soc_pkg::mem_data_t wd_a, input logic we_b, input soc_pkg::mem_addr_t addr_b,
         input soc_pkg::mem_data_t wd_b, input string tag);
      soc_pkg::mem_data_t exp_a, exp_b, got_a, got_b;
      int   lat_a, lat_b;
      logic a_first;
      a_first = ~ref_ptr;
      if (a_first) begin
         exp_a = ref_access(we_a, addr_a, wd_a);
         exp_b = ref_access(we_b, addr_b, wd_b);
      end else begin
         exp_b = ref_access(we_b, addr_b, wd_b);
         exp_a = ref_access(we_a, addr_a, wd_a);
      end
      ref_ptr = a_first;                    // Loser favored next time.
      fork
         run_access(1'b0, we_a, addr_a, wd_a, got_a, lat_a);
         run_access(1'b1, we_b, addr_b, wd_b, got_b, lat_b);
      join
      check_value(lat_a, a_first ? 2 : 3, {tag, " A latency"});
      check_value(lat_b, a_first ? 3 : 2, {tag, " B latency"});
      check_value(got_a, exp_a, {tag, " A rdata"});
      check_value(got_b, exp_b, {tag, " B rdata"});
   endtask

   //----------------------------------------------------------------------
   // Tests
   //----------------------------------------------------------------------

   task automatic test_init();
      int   e;
      logic saw;
      e = errors;
      apply_reset();
      wait_ready(1'b1, saw);
      check_value(32'(saw), 32'd0, "done pulse for strobe before ready");
      report("init", e);
   endtask

   task automatic test_cleared();
      int e;
      soc_pkg::mem_addr_t addrs [8] = '{8'h00, 8'h01, 8'h02, 8'h55,
                                        8'h80, 8'haa, 8'hfe, 8'hff};
      e = errors;
      for (int i = 0; i < 8; i++) single_access(i[0], 1'b0, addrs[i], '0, "cleared read");
      report("cleared", e);
   endtask

   task automatic test_write();
      int e;
      e = errors;
      single_access(1'b0, 1'b1, 8'h10, 32'hdead_beef, "first write");
      single_access(1'b1, 1'b1, 8'h10, 32'h1234_5678, "overwrite");
      single_access(1'b0, 1'b0, 8'h10, '0, "read back");
      report("write", e);
   endtask

   task automatic test_contention();
      int e;
      e = errors;
      for (int i = 0; i < 4; i++)
         paired_access(1'b0, 8'(i), '0, 1'b0, 8'(i + 4), '0, "contended read");
      paired_access(1'b1, 8'h20, 32'haaaa_0001, 1'b0, 8'h20, '0, "write vs read");
      paired_access(1'b0, 8'h20, '0, 1'b1, 8'h20, 32'hbbbb_0002, "read vs write");
      report("contention", e);
   endtask

   task automatic test_random();
      int e, mode;
      logic we_a, we_b;
      soc_pkg::mem_addr_t ad_a, ad_b;
      soc_pkg::mem_data_t wd_a, wd_b;
      e = errors;
      repeat (N_RAND) begin
         mode = $urandom_range(2);
         we_a = 1'($urandom_range(1));
         we_b = 1'($urandom_range(1));
         ad_a = soc_pkg::mem_addr_t'($urandom_range(15)); // Small range, many hits.
         ad_b = soc_pkg::mem_addr_t'($urandom_range(15));
         wd_a = $urandom;
         wd_b = $urandom;
         if (mode == 0) single_access(1'b0, we_a, ad_a, wd_a, "random A");
         else if (mode == 1) single_access(1'b1, we_b, ad_b, wd_b, "random B");
         else paired_access(we_a, ad_a, wd_a, we_b, ad_b, wd_b, "random pair");
      end
      report("random", e);
   endtask

   task automatic test_reset_again();
      int   e;
      logic saw;
      e = errors;
      for (int i = 0; i < 4; i++)
         single_access(i[0], 1'b1, 8'(8'h40 + i), 32'hc0de_0000 + 32'(i), "pre-reset write");
      apply_reset();
      wait_ready(1'b0, saw);
      for (int i = 0; i < 4; i++)
         single_access(i[0], 1'b0, 8'(8'h40 + i), '0, "read after reset");
      report("reset again", e);
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      a_req = 1'b0;
      a_we = 1'b0;
      a_addr = '0;
      a_wdata = '0;
      b_req = 1'b0;
      b_we = 1'b0;
      b_addr = '0;
      b_wdata = '0;
      ref_ptr = 1'b0;
      void'($urandom(89));
      test_init();
      test_cleared();
      test_write();
      test_contention();
      test_random();
      test_reset_again();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) $display("Finished with no errors");
      else $display("Finished with errors");
      $finish;
   end

endmodule
